// ==== reindeer_lite.f ====
hw/rv_pkg.sv
hw/mem_req_if.sv
hw/core_ctrl.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/alu_exec.sv
hw/mem_master.sv
hw/reindeer_lite_top.sv
test/tb_reindeer_lite.sv

// ==== test/tb_reindeer_lite.sv ====
// tb_reindeer_lite
// testbench for the reindeer lite core: four-phase memory model with
// random ack delay, a table of small programs, result checks, watchdog

`timescale 1ns/1ps

module tb_reindeer_lite import rv_pkg::*; ();

    localparam int    CLK_PERIOD = 4;
    localparam word_t PROG_ADDR  = 32'h0000_0040;
    localparam word_t RES_ADDR   = 32'h0000_0200;
    localparam word_t MARK_ADDR  = 32'h0000_0204;
    localparam word_t LOAD_ADDR  = 32'h0000_0208;
    localparam word_t MARK_VAL   = 32'h0000_0123;
    localparam word_t EBREAK     = 32'h0010_0073;

    // test operations
    localparam int OP_ADD   = 0;
    localparam int OP_SUB   = 1;
    localparam int OP_AND   = 2;
    localparam int OP_OR    = 3;
    localparam int OP_XOR   = 4;
    localparam int OP_SLT   = 5;
    localparam int OP_ADDI  = 6;
    localparam int OP_LWINC = 7;
    localparam int OP_BEQ   = 8;
    localparam int OP_BNE   = 9;
    localparam int OP_JAL   = 10;

    logic  clk;
    logic  rst_n_i;
    logic  start_i;
    word_t start_addr_i;
    logic  mem_req_o;
    logic  mem_we_o;
    word_t mem_addr_o;
    word_t mem_wdata_o;
    logic  mem_ack_i;
    word_t mem_rdata_i;
    logic  paused_o;
    word_t peek_pc_o;
    word_t peek_ir_o;

    // memory model state
    word_t  mem [0:255];
    integer seed = 32'h79e0b3e0;
    int     ack_wait;
    logic   serving;
    int     rel_wait;
    logic   releasing;
    logic   req_prev;
    word_t  skip_addr;
    logic   skip_hit;

    // program builder state
    int    pc_word;
    word_t halt_addr;

    // test table
    string t_name[$];
    int    t_op[$];
    word_t t_a[$];
    word_t t_b[$];
    word_t t_exp[$];
    logic  table_ready = 1'b0;

    reindeer_lite_top dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (start_i),
        .start_addr_i (start_addr_i),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i),
        .paused_o     (paused_o),
        .peek_pc_o    (peek_pc_o),
        .peek_ir_o    (peek_ir_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // failure reporting and compares
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
        end
    endtask

    // --------------------------------------------------
    // four-phase memory model, acts 1 ns after each rising edge
    // --------------------------------------------------
    task automatic serve_access();
        int idx;
        if (mem_addr_o[31:10] != '0 || mem_addr_o[1:0] != 2'b00) begin
            abort_run("memory access outside the model or not word aligned");
        end
        idx = mem_addr_o[9:2];
        if (mem_we_o) begin
            mem[idx] = mem_wdata_o;
        end else begin
            mem_rdata_i = mem[idx];
            if (mem_addr_o == skip_addr) begin
                skip_hit = 1'b1;
            end
        end
    endtask

    initial begin
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        serving     = 1'b0;
        releasing   = 1'b0;
        req_prev    = 1'b0;
        ack_wait    = 0;
        rel_wait    = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst_n_i) begin
                mem_ack_i = 1'b0;
                serving   = 1'b0;
                releasing = 1'b0;
            end else begin
                if (mem_req_o && !req_prev && mem_ack_i) begin
                    abort_run("a new request rose while ack was still high");
                end
                if (mem_req_o && !req_prev && paused_o) begin
                    abort_run("a request rose after the core had halted");
                end
                if (mem_req_o && !mem_ack_i) begin
                    // ack delay of 0 to 3 cycles per access
                    if (!serving) begin
                        serving  = 1'b1;
                        ack_wait = $unsigned($random(seed)) % 4;
                    end
                    if (ack_wait == 0) begin
                        serve_access();
                        mem_ack_i = 1'b1;
                        serving   = 1'b0;
                    end else begin
                        ack_wait = ack_wait - 1;
                    end
                end else if (!mem_req_o && mem_ack_i) begin
                    // ack release held off 0 to 3 cycles as well
                    if (!releasing) begin
                        releasing = 1'b1;
                        rel_wait  = $unsigned($random(seed)) % 4;
                    end
                    if (rel_wait == 0) begin
                        mem_ack_i = 1'b0;
                        releasing = 1'b0;
                    end else begin
                        rel_wait = rel_wait - 1;
                    end
                end
            end
            req_prev = mem_req_o;
        end
    end

    // --------------------------------------------------
    // RV32I encoders and program builder
    // --------------------------------------------------
    function automatic word_t enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                    input logic [4:0] rd, input logic [4:0] rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_r(input int op, input logic [4:0] rd,
                                    input logic [4:0] rs1, input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'h00;
        case (op)
            OP_SUB: begin
                f3 = 3'b000;
                f7 = 7'h20;
            end
            OP_AND:  f3 = 3'b111;
            OP_OR:   f3 = 3'b110;
            OP_XOR:  f3 = 3'b100;
            OP_SLT:  f3 = 3'b010;
            default: f3 = 3'b000;
        endcase
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // SW rs2, imm(rs1)
    function automatic word_t enc_sw(input logic [4:0] rs1, input logic [4:0] rs2,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                    input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input word_t instr);
        mem[pc_word] = instr;
        pc_word = pc_word + 1;
    endtask

    // always two words, LUI then ADDI with the carry folded into the upper part
    task automatic emit_li(input logic [4:0] rd, input word_t value);
        word_t upper;
        upper = value + 32'h800;
        emit(enc_lui(rd, upper[31:12]));
        emit(enc_i(7'b0010011, 3'b000, rd, rd, value[11:0]));
    endtask

    task automatic load_program(input int op, input word_t a, input word_t b);
        // low bits 00 never form a valid opcode, so a stray fetch halts
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a5a_0000 | word_t'(i << 2);
        end
        pc_word   = PROG_ADDR[9:2];
        skip_addr = '1;
        skip_hit  = 1'b0;
        case (op)
            OP_LWINC: begin
                mem[LOAD_ADDR[9:2]] = a;
                emit(enc_i(7'b0000011, 3'b010, 5'd1, 5'd0, LOAD_ADDR[11:0]));
                emit(enc_i(7'b0010011, 3'b000, 5'd1, 5'd1, 12'd1));
                emit(enc_sw(5'd0, 5'd1, RES_ADDR[11:0]));
            end
            OP_JAL: begin
                // link in x1, the next word must never be fetched
                emit(enc_jal(5'd1, 21'd8));
                skip_addr = PROG_ADDR + 32'd4;
                emit(enc_i(7'b0010011, 3'b000, 5'd1, 5'd0, 12'd7));
                emit(enc_sw(5'd0, 5'd1, RES_ADDR[11:0]));
            end
            OP_BEQ, OP_BNE: begin
                emit_li(5'd1, a);
                emit_li(5'd2, b);
                emit(enc_i(7'b0010011, 3'b000, 5'd5, 5'd0, MARK_VAL[11:0]));
                emit(enc_b((op == OP_BNE) ? 3'b001 : 3'b000, 5'd1, 5'd2, 13'd8));
                emit(enc_sw(5'd0, 5'd5, MARK_ADDR[11:0]));
            end
            OP_ADDI: begin
                emit_li(5'd1, a);
                emit(enc_i(7'b0010011, 3'b000, 5'd3, 5'd1, b[11:0]));
                emit(enc_sw(5'd0, 5'd3, RES_ADDR[11:0]));
            end
            default: begin
                emit_li(5'd1, a);
                emit_li(5'd2, b);
                emit(enc_r(op, 5'd3, 5'd1, 5'd2));
                emit(enc_sw(5'd0, 5'd3, RES_ADDR[11:0]));
            end
        endcase
        halt_addr = word_t'(pc_word << 2);
        emit(EBREAK);
    endtask

    // --------------------------------------------------
    // expected results and the test table
    // --------------------------------------------------
    function automatic word_t expected_value(input int op, input word_t a, input word_t b);
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI:  return a + {{20{b[11]}}, b[11:0]};
            OP_LWINC: return a + 32'd1;
            // marker store only when the branch falls through
            OP_BEQ:   return (a != b) ? 32'd1 : 32'd0;
            OP_BNE:   return (a == b) ? 32'd1 : 32'd0;
            default:  return PROG_ADDR + 32'd4;
        endcase
    endfunction

    task automatic add_entry(input string name, input int op, input word_t a, input word_t b);
        t_name.push_back(name);
        t_op.push_back(op);
        t_a.push_back(a);
        t_b.push_back(b);
        t_exp.push_back(expected_value(op, a, b));
    endtask

    task automatic build_table();
        add_entry("add_overflow", OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        add_entry("add_negative", OP_ADD, 32'hffff_fffb, 32'h0000_0003);
        add_entry("sub_overflow", OP_SUB, 32'h8000_0000, 32'h0000_0001);
        add_entry("sub_negative", OP_SUB, 32'h0000_0003, 32'h0000_000a);
        add_entry("and_mixed", OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00);
        add_entry("or_mixed", OP_OR, 32'h8000_0800, 32'h0000_07ff);
        add_entry("xor_mixed", OP_XOR, 32'hdead_beef, 32'hffff_0000);
        add_entry("slt_neg_pos", OP_SLT, 32'hffff_ffff, 32'h0000_0001);
        add_entry("slt_pos_neg", OP_SLT, 32'h0000_0005, 32'hffff_fff9);
        add_entry("slt_min_max", OP_SLT, 32'h8000_0000, 32'h7fff_ffff);
        add_entry("addi_overflow", OP_ADDI, 32'h7fff_ffff, 32'h0000_0001);
        add_entry("addi_negative", OP_ADDI, 32'h0000_0064, 32'hffff_ff38);
        add_entry("lw_add_sw", OP_LWINC, 32'h1234_ffff, 32'h0000_0000);
        add_entry("beq_equal", OP_BEQ, 32'h0000_0042, 32'h0000_0042);
        add_entry("beq_unequal", OP_BEQ, 32'h0000_0042, 32'h8000_0042);
        add_entry("bne_equal", OP_BNE, 32'hffff_fff0, 32'hffff_fff0);
        add_entry("bne_unequal", OP_BNE, 32'h0000_0001, 32'h0000_0002);
        add_entry("jal_link", OP_JAL, 32'h0000_0000, 32'h0000_0000);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(input int k);
        load_program(t_op[k], t_a[k], t_b[k]);
        rst_n_i = 1'b0;
        repeat (5) next_cycle();
        rst_n_i = 1'b1;
        // quiet until started
        repeat (3) begin
            next_cycle();
            check_flag($sformatf("%s idle req", t_name[k]), 1'b0, mem_req_o);
            check_flag($sformatf("%s idle paused", t_name[k]), 1'b0, paused_o);
        end
        start_addr_i = PROG_ADDR;
        start_i      = 1'b1;
        next_cycle();
        start_i = 1'b0;
        while (!paused_o) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        check_flag($sformatf("%s still paused", t_name[k]), 1'b1, paused_o);
        check_flag($sformatf("%s req after halt", t_name[k]), 1'b0, mem_req_o);
        check_word($sformatf("%s halt pc", t_name[k]), halt_addr, peek_pc_o);
        check_word($sformatf("%s halt ir", t_name[k]), EBREAK, peek_ir_o);
        if (t_op[k] == OP_BEQ || t_op[k] == OP_BNE) begin
            check_flag(t_name[k], t_exp[k][0], mem[MARK_ADDR[9:2]] == MARK_VAL);
        end else begin
            check_word(t_name[k], t_exp[k], mem[RES_ADDR[9:2]]);
        end
        if (t_op[k] == OP_JAL) begin
            check_flag($sformatf("%s fall-through fetch", t_name[k]), 1'b0, skip_hit);
        end
    endtask

    initial begin
        rst_n_i      = 1'b0;
        start_i      = 1'b0;
        start_addr_i = '0;
        build_table();
        table_ready = 1'b1;
        for (int k = 0; k < t_op.size(); k++) begin
            run_test(k);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // watchdog, 400 cycles per table entry
    initial begin
        wait (table_ready);
        #(t_op.size() * 400 * CLK_PERIOD);
        abort_run("timeout: the core did not get through the test table in time");
    end

endmodule

// ==== hw/reindeer_lite_top.sv ====
// reindeer_lite_top
// multicycle RV32I core top level; controller, datapath and the
// four-phase memory master on one shared memory port

`timescale 1ns/1ps

module reindeer_lite_top import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  start_i,
    input  word_t start_addr_i,
    output logic  mem_req_o,
    output logic  mem_we_o,
    output word_t mem_addr_o,
    output word_t mem_wdata_o,
    input  logic  mem_ack_i,
    input  word_t mem_rdata_i,
    output logic  paused_o,
    output word_t peek_pc_o,
    output word_t peek_ir_o
);

    // --------------------------------------------------
    // control strobes and decode
    // --------------------------------------------------
    logic pc_init, pc_load, take_target, ir_load;
    logic exec_en, rd_we, wb_sel_mem;
    logic use_imm, branch_ne, branch_taken;
    instr_class_e instr_class;
    alu_op_e      alu_op;
    reg_addr_t    rs1, rs2, rd;

    // datapath words
    word_t imm, pc_plus4, target, result, store_data;
    word_t rs1_data, rs2_data, wb_data;

    mem_req_if mif ();

    core_ctrl core_ctrl_i (
        .clk (clk), .rst_n_i (rst_n_i), .start_i (start_i),
        .instr_class_i (instr_class), .branch_taken_i (branch_taken),
        .mif (mif.ctrl_mp),
        .pc_init_o (pc_init), .pc_load_o (pc_load), .take_target_o (take_target),
        .ir_load_o (ir_load), .exec_en_o (exec_en), .rd_we_o (rd_we),
        .wb_sel_mem_o (wb_sel_mem), .paused_o (paused_o));

    fetch_unit fetch_unit_i (
        .clk (clk), .rst_n_i (rst_n_i),
        .pc_init_i (pc_init), .start_addr_i (start_addr_i),
        .pc_load_i (pc_load), .take_target_i (take_target), .target_i (target),
        .ir_load_i (ir_load), .rdata_i (mif.rdata),
        .pc_o (peek_pc_o), .pc_plus4_o (pc_plus4), .ir_o (peek_ir_o));

    decode_unit decode_unit_i (
        .ir_i (peek_ir_o), .instr_class_o (instr_class), .alu_op_o (alu_op),
        .use_imm_o (use_imm), .imm_o (imm),
        .rs1_o (rs1), .rs2_o (rs2), .rd_o (rd), .branch_ne_o (branch_ne));

    reg_file reg_file_i (
        .clk (clk), .rst_n_i (rst_n_i),
        .rs1_i (rs1), .rs2_i (rs2), .rd_i (rd), .we_i (rd_we), .wdata_i (wb_data),
        .rs1_data_o (rs1_data), .rs2_data_o (rs2_data));

    alu_exec alu_exec_i (
        .clk (clk), .rst_n_i (rst_n_i), .exec_en_i (exec_en),
        .instr_class_i (instr_class), .alu_op_i (alu_op),
        .use_imm_i (use_imm), .imm_i (imm), .pc_i (peek_pc_o), .pc_plus4_i (pc_plus4),
        .rs1_data_i (rs1_data), .rs2_data_i (rs2_data), .branch_ne_i (branch_ne),
        .load_word_i (mif.rdata), .wb_sel_mem_i (wb_sel_mem),
        .result_o (result), .target_o (target), .branch_taken_o (branch_taken),
        .store_data_o (store_data), .wb_data_o (wb_data));

    mem_master mem_master_i (
        .clk (clk), .rst_n_i (rst_n_i),
        .pc_i (peek_pc_o), .addr_i (result), .wdata_i (store_data),
        .mem_ack_i (mem_ack_i), .mem_rdata_i (mem_rdata_i),
        .mif (mif.mem_mp),
        .mem_req_o (mem_req_o), .mem_we_o (mem_we_o),
        .mem_addr_o (mem_addr_o), .mem_wdata_o (mem_wdata_o));

endmodule

// ==== hw/mem_master.sv ====
// mem_master
// four-phase req/ack master on the shared instruction and data port;
// address and write data stay registered for the whole cycle

`timescale 1ns/1ps

module mem_master import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  word_t    pc_i,
    input  word_t    addr_i,
    input  word_t    wdata_i,
    input  logic     mem_ack_i,
    input  word_t    mem_rdata_i,
    mem_req_if.mem_mp mif,
    output logic     mem_req_o,
    output logic     mem_we_o,
    output word_t    mem_addr_o,
    output word_t    mem_wdata_o
);

    typedef enum logic [1:0] {M_IDLE, M_REQ, M_RELEASE, M_DONE} phase_e;

    phase_e phase_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q   <= M_IDLE;
            mem_req_o <= 1'b0;
            mem_we_o  <= 1'b0;
        end else begin
            case (phase_q)
                M_IDLE: begin
                    if (mif.req) begin
                        phase_q   <= M_REQ;
                        mem_req_o <= 1'b1;
                        mem_we_o  <= mif.we;
                    end
                end
                // memory may hold off ack as long as it likes
                M_REQ: begin
                    if (mem_ack_i) begin
                        phase_q   <= M_RELEASE;
                        mem_req_o <= 1'b0;
                        mem_we_o  <= 1'b0;
                    end
                end
                // no new request before ack is seen low
                M_RELEASE: if (!mem_ack_i) phase_q <= M_DONE;
                default:   phase_q <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase_q == M_IDLE && mif.req) begin
            mem_addr_o  <= mif.data_phase ? addr_i : pc_i;
            mem_wdata_o <= wdata_i;
        end
        if (phase_q == M_REQ && mem_ack_i) begin
            mif.rdata <= mem_rdata_i;
        end
    end

    assign mif.done = (phase_q == M_DONE);

endmodule

// ==== hw/alu_exec.sv ====
// alu_exec
// operand select, ALU, branch compare and target adder, registered on
// exec; also picks the writeback word

`timescale 1ns/1ps

module alu_exec import rv_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         exec_en_i,
    input  instr_class_e instr_class_i,
    input  alu_op_e      alu_op_i,
    input  logic         use_imm_i,
    input  word_t        imm_i,
    input  word_t        pc_i,
    input  word_t        pc_plus4_i,
    input  word_t        rs1_data_i,
    input  word_t        rs2_data_i,
    input  logic         branch_ne_i,
    input  word_t        load_word_i,
    input  logic         wb_sel_mem_i,
    output word_t        result_o,
    output word_t        target_o,
    output logic         branch_taken_o,
    output word_t        store_data_o,
    output word_t        wb_data_o
);

    word_t op_b;
    word_t alu_out;

    assign op_b = use_imm_i ? imm_i : rs2_data_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_out = rs1_data_i + op_b;
            ALU_SUB:    alu_out = rs1_data_i - op_b;
            ALU_AND:    alu_out = rs1_data_i & op_b;
            ALU_OR:     alu_out = rs1_data_i | op_b;
            ALU_XOR:    alu_out = rs1_data_i ^ op_b;
            ALU_SLT:    alu_out = word_t'($signed(rs1_data_i) < $signed(op_b));
            default:    alu_out = op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            branch_taken_o <= 1'b0;
        end else if (exec_en_i) begin
            // equality, inverted for BNE
            branch_taken_o <= (rs1_data_i == rs2_data_i) ^ branch_ne_i;
        end
    end

    // result doubles as the LW/SW address
    always_ff @(posedge clk) begin
        if (exec_en_i) begin
            result_o     <= (instr_class_i == IC_JAL) ? pc_plus4_i : alu_out;
            target_o     <= pc_i + imm_i;
            store_data_o <= rs2_data_i;
        end
    end

    assign wb_data_o = wb_sel_mem_i ? load_word_i : result_o;

endmodule

// ==== hw/reg_file.sv ====
// reg_file
// 32 x 32 integer registers, two registered read ports, one write port;
// x0 reads as zero and ignores writes

`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  logic      we_i,
    input  word_t     wdata_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    // no storage behind x0
    word_t regs [1:2**REG_ADDR_BITS-1];

    always_ff @(posedge clk) begin
        if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rs1_data_o <= '0;
            rs2_data_o <= '0;
        end else begin
            rs1_data_o <= (rs1_i == '0) ? '0 : regs[rs1_i];
            rs2_data_o <= (rs2_i == '0) ? '0 : regs[rs2_i];
        end
    end

endmodule

// ==== hw/decode_unit.sv ====
// decode_unit
// combinational decode: register fields, immediates, ALU operation
// and instruction class; anything unsupported decodes to halt

`timescale 1ns/1ps

module decode_unit import rv_pkg::*; (
    input  word_t        ir_i,
    output instr_class_e instr_class_o,
    output alu_op_e      alu_op_o,
    output logic         use_imm_o,
    output word_t        imm_o,
    output reg_addr_t    rs1_o,
    output reg_addr_t    rs2_o,
    output reg_addr_t    rd_o,
    output logic         branch_ne_o
);

    logic [2:0] funct3;
    alu_op_e    f3_op;
    logic       f3_ok;
    word_t      imm_i_fmt;
    word_t      imm_s_fmt;
    word_t      imm_b_fmt;
    word_t      imm_u_fmt;
    word_t      imm_j_fmt;

    assign funct3 = ir_i[14:12];
    assign rd_o   = ir_i[11:7];
    assign rs1_o  = ir_i[19:15];
    assign rs2_o  = ir_i[24:20];

    // BEQ is 000, BNE is 001
    assign branch_ne_o = funct3[0];

    // --------------------------------------------------
    // immediate formats
    // --------------------------------------------------
    assign imm_i_fmt = {{20{ir_i[31]}}, ir_i[31:20]};
    assign imm_s_fmt = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_b_fmt = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    assign imm_u_fmt = {ir_i[31:12], 12'b0};
    assign imm_j_fmt = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

    // funct3 mapping shared by OP and OP-IMM
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            3'b000:  f3_op = ALU_ADD;
            3'b010:  f3_op = ALU_SLT;
            3'b100:  f3_op = ALU_XOR;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        instr_class_o = IC_HALT;
        alu_op_o      = ALU_ADD;
        use_imm_o     = 1'b0;
        imm_o         = imm_i_fmt;
        case (ir_i[6:0])
            OPC_LUI: begin
                instr_class_o = IC_ALU;
                alu_op_o      = ALU_PASS_B;
                use_imm_o     = 1'b1;
                imm_o         = imm_u_fmt;
            end
            OPC_OPIMM: begin
                if (f3_ok) instr_class_o = IC_ALU;
                alu_op_o  = f3_op;
                use_imm_o = 1'b1;
            end
            OPC_OP: begin
                if (f3_ok) instr_class_o = IC_ALU;
                alu_op_o = (funct3 == 3'b000 && ir_i[30]) ? ALU_SUB : f3_op;
            end
            OPC_BRANCH: begin
                if (funct3[2:1] == 2'b00) instr_class_o = IC_BRANCH;
                imm_o = imm_b_fmt;
            end
            OPC_JAL: begin
                instr_class_o = IC_JAL;
                imm_o         = imm_j_fmt;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) instr_class_o = IC_LOAD;
                use_imm_o = 1'b1;
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) instr_class_o = IC_STORE;
                use_imm_o = 1'b1;
                imm_o     = imm_s_fmt;
            end
            // EBREAK and the rest of SYSTEM stop the core
            OPC_SYSTEM: instr_class_o = IC_HALT;
            default:    instr_class_o = IC_HALT;
        endcase
    end

endmodule

// ==== hw/fetch_unit.sv ====
// fetch_unit
// program counter with next-PC selection, and the instruction register

`timescale 1ns/1ps

module fetch_unit import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  pc_init_i,
    input  word_t start_addr_i,
    input  logic  pc_load_i,
    input  logic  take_target_i,
    input  word_t target_i,
    input  logic  ir_load_i,
    input  word_t rdata_i,
    output word_t pc_o,
    output word_t pc_plus4_o,
    output word_t ir_o
);

    word_t pc_q;
    word_t ir_q;

    // sequential successor, also the JAL link value
    assign pc_plus4_o = pc_q + ADDR_BITS'(4);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
            ir_q <= '0;
        end else begin
            if (pc_init_i) begin
                pc_q <= start_addr_i;
            end else if (pc_load_i) begin
                pc_q <= take_target_i ? target_i : pc_plus4_o;
            end
            if (ir_load_i) begin
                ir_q <= rdata_i;
            end
        end
    end

    assign pc_o = pc_q;
    assign ir_o = ir_q;

endmodule

// ==== hw/core_ctrl.sv ====
// core_ctrl
// multicycle FSM, one instruction in flight: fetch, register read,
// execute, optional memory access, then writeback and PC update

`timescale 1ns/1ps

module core_ctrl import rv_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         start_i,
    input  instr_class_e instr_class_i,
    input  logic         branch_taken_i,
    mem_req_if.ctrl_mp   mif,
    output logic         pc_init_o,
    output logic         pc_load_o,
    output logic         take_target_o,
    output logic         ir_load_o,
    output logic         exec_en_o,
    output logic         rd_we_o,
    output logic         wb_sel_mem_o,
    output logic         paused_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:  if (start_i) state_d = S_FETCH;
            S_FETCH: if (mif.done) state_d = S_READ;
            S_READ:  state_d = S_EXEC;
            S_EXEC: begin
                // class is known here, IR is stable since FETCH
                if (instr_class_i == IC_HALT) begin
                    state_d = S_HALT;
                end else if (instr_class_i == IC_LOAD || instr_class_i == IC_STORE) begin
                    state_d = S_MEM;
                end else begin
                    state_d = S_WB;
                end
            end
            S_MEM:   if (mif.done) state_d = S_WB;
            S_WB:    state_d = S_FETCH;
            // only reset leaves halt
            default: state_d = S_HALT;
        endcase
    end

    // --------------------------------------------------
    // strobes and memory request
    // --------------------------------------------------
    assign pc_init_o = (state_q == S_IDLE) && start_i;
    assign ir_load_o = (state_q == S_FETCH) && mif.done;
    assign exec_en_o = (state_q == S_EXEC);
    assign pc_load_o = (state_q == S_WB);

    // the single branch/jump decision of the core
    assign take_target_o = pc_load_o && ((instr_class_i == IC_JAL) ||
                           ((instr_class_i == IC_BRANCH) && branch_taken_i));

    assign rd_we_o = pc_load_o && ((instr_class_i == IC_ALU) ||
                     (instr_class_i == IC_JAL) || (instr_class_i == IC_LOAD));
    assign wb_sel_mem_o = (instr_class_i == IC_LOAD);
    assign paused_o     = (state_q == S_HALT);

    assign mif.req        = (state_q == S_FETCH) || (state_q == S_MEM);
    assign mif.data_phase = (state_q == S_MEM);
    assign mif.we         = (state_q == S_MEM) && (instr_class_i == IC_STORE);

endmodule

// ==== hw/mem_req_if.sv ====
// mem_req_if
// request channel between the core FSM and the external memory master

`timescale 1ns/1ps

interface mem_req_if import rv_pkg::*; ();

    // access request, held high until done
    logic  req;
    logic  we;
    // low selects the PC, high the ALU address
    logic  data_phase;
    // one clock at the end of the four-phase cycle
    logic  done;
    // read word captured on ack
    word_t rdata;

    modport ctrl_mp (output req, output we, output data_phase, input done);

    modport mem_mp (input req, input we, input data_phase, output done, output rdata);

endinterface

// ==== hw/rv_pkg.sv ====
// rv_pkg
// shared widths, opcodes, ALU operations, instruction classes and
// controller states for the reindeer lite RV32I core

package rv_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int XLEN          = 32;
    localparam int REG_ADDR_BITS = 5;
    localparam int ADDR_BITS     = 32;

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;

    // --------------------------------------------------
    // major opcodes, bits 6:0 of the instruction
    // --------------------------------------------------
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // --------------------------------------------------
    // datapath and control encodings
    // --------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    // what the controller does with the instruction
    typedef enum logic [2:0] {
        IC_ALU, IC_BRANCH, IC_JAL, IC_LOAD, IC_STORE, IC_HALT
    } instr_class_e;

    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_READ, S_EXEC, S_MEM, S_WB, S_HALT
    } ctrl_state_e;

endpackage
